//--- common/scroll_cfg.svh
`ifndef SCROLL_CFG_SVH
`define SCROLL_CFG_SVH

// tilemap scan
`define SCR_COLS       21          // tile columns fetched per line
`define SCR_MAP_AW     13          // tilemap word address
`define SCR_MAX_TILE   17'h1FFFF   // highest tile number that draws

// priority queue
`define SCR_PRI_LEVELS 16
`define SCR_Q_AW       9           // 16 levels of 21 slots fit in 512

// line buffer side
`define SCR_VISIBLE_W  320         // pixels 0..319 are written
`define SCR_BUF_AW     9

`endif

//--- common/scroll_pkg.sv
package scroll_pkg;

    // one queued tile, as it sits in the queue RAM
    typedef struct packed {
        logic [15:0]        attr;  // [11:8] priority, [6:0] palette
        logic [15:0]        tile;
        logic signed [15:0] xpos;  // screen x of the tile's left edge
        logic signed [15:0] ypos;
    } tile_entry_t;

    // one 32-bit graphics slice, 8 pixels across
    typedef union packed {
        logic [31:0]     raw;
        logic [7:0][3:0] pix;      // pix[0] sits in the low nibble
    } gfx_slice_u;

    // line buffer word
    typedef struct packed {
        logic [3:0] pri;
        logic [6:0] pal;
        logic [3:0] code;          // zero never reaches the buffer
    } pix_word_t;

endpackage

//--- scroll_layer/tilemap_scan.sv
`timescale 1ns/1ps
`include "scroll_cfg.svh"

module tilemap_scan
    import scroll_pkg::*;
(
    input  logic                   CLK96,
    input  logic                   RESET96,
    input  logic                   hb_i,
    input  logic                   vb_i,
    input  logic [8:0]             vrender_i,
    input  logic signed [12:0]     scroll_x_i,
    input  logic signed [12:0]     scroll_y_i,
    input  logic [15:0]            map_dout_i,
    input  logic                   line_done_i,
    output logic [`SCR_MAP_AW-1:0] map_addr_o,
    output logic                   push_o,
    output tile_entry_t            entry_o,
    output logic [3:0]             push_pri_o,
    output logic                   scan_done_o,
    output logic                   busy_o,
    output logic                   done_o
);

    typedef enum logic [2:0] {
        S_IDLE, S_TILE_ADDR, S_ATTR_ADDR, S_TILE, S_ATTR, S_WAIT
    } scan_st_t;

    scan_st_t    st;
    logic        hb_l;
    logic [4:0]  col;        // 0..21, 21 ends the scan
    logic [5:0]  tile_row;   // tile row of the rendered line
    logic [15:0] tile_q;

    wire hb_fall    = hb_l && !hb_i;
    wire line_start = hb_fall && (!vb_i || vrender_i == 9'd0);

    // line plus fine y, upper bits give the tile row
    wire [9:0] line_fine = {1'b0, vrender_i} + {6'd0, scroll_y_i[3:0]};

    // coarse scroll plus position, wraps at 32 tiles both ways
    wire [4:0] map_row = scroll_y_i[8:4] + tile_row[4:0];
    wire [4:0] map_col = scroll_x_i[8:4] + col;

    wire tile_kept = (map_dout_i != 16'd0) && ({1'b0, map_dout_i} <= `SCR_MAX_TILE);

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            st          <= S_IDLE;
            hb_l        <= 1'b0;
            col         <= 5'd0;
            tile_row    <= 6'd0;
            push_o      <= 1'b0;
            scan_done_o <= 1'b0;
            busy_o      <= 1'b0;
            done_o      <= 1'b0;
        end else begin
            hb_l        <= hb_i;
            push_o      <= 1'b0;
            scan_done_o <= 1'b0;
            done_o      <= 1'b0;
            case (st)
                S_IDLE: if (line_start) begin   // starts while busy never get here
                    busy_o   <= 1'b1;
                    col      <= 5'd0;
                    tile_row <= line_fine[9:4];
                    st       <= S_TILE_ADDR;
                end
                S_TILE_ADDR: begin
                    if (col == 5'(`SCR_COLS)) begin
                        scan_done_o <= 1'b1;
                        st          <= S_WAIT;
                    end else begin
                        st <= S_ATTR_ADDR;
                    end
                end
                S_ATTR_ADDR: st <= S_TILE;
                S_TILE: begin
                    if (tile_kept) begin
                        st <= S_ATTR;
                    end else begin
                        col <= col + 5'd1;   // blank, 3 cycles for this column
                        st  <= S_TILE_ADDR;
                    end
                end
                S_ATTR: begin
                    push_o <= 1'b1;
                    col    <= col + 5'd1;
                    st     <= S_TILE_ADDR;
                end
                S_WAIT: if (line_done_i) begin
                    busy_o <= 1'b0;
                    done_o <= 1'b1;
                    st     <= S_IDLE;
                end
                default: st <= S_IDLE;
            endcase
        end
    end

    // map address and entry fields
    always_ff @(posedge CLK96) begin
        case (st)
            S_TILE_ADDR: map_addr_o <= {2'b00, map_row, map_col, 1'b1};  // tile word
            S_ATTR_ADDR: map_addr_o <= {2'b00, map_row, map_col, 1'b0};  // attribute
            S_TILE:      tile_q <= map_dout_i;
            S_ATTR: begin
                entry_o.attr <= map_dout_i;
                entry_o.tile <= tile_q;
                entry_o.xpos <= {7'd0, col, 4'd0} - {12'd0, scroll_x_i[3:0]};
                entry_o.ypos <= {6'd0, tile_row, 4'd0} - {12'd0, scroll_y_i[3:0]};
                push_pri_o   <= map_dout_i[11:8];
            end
            default: ;
        endcase
    end

endmodule

//--- scroll_layer/pri_queue.sv
`timescale 1ns/1ps
`include "scroll_cfg.svh"

module pri_queue
    import scroll_pkg::*;
(
    input  logic        CLK96,
    input  logic        RESET96,
    input  logic        push_i,
    input  tile_entry_t entry_i,
    input  logic [3:0]  push_pri_i,
    input  logic        scan_done_i,
    input  logic        tile_done_i,
    output logic        ent_valid_o,
    output tile_entry_t ent_o,
    output logic [3:0]  ent_pri_o,
    output logic        line_done_o
);

    localparam int QDEPTH = `SCR_PRI_LEVELS * `SCR_COLS;

    typedef enum logic [1:0] {Q_IDLE, Q_PICK, Q_READ, Q_WAIT} q_st_t;

    tile_entry_t                q_ram [QDEPTH];
    logic [4:0]                 cnt [`SCR_PRI_LEVELS];  // entries per level
    logic [`SCR_PRI_LEVELS-1:0] occupied;
    q_st_t                      st;
    logic [3:0]                 lvl;       // level being drained
    logic [4:0]                 rd_idx;
    logic [3:0]                 low_lvl;

    // slot of an entry, priority*21 + index
    function automatic logic [`SCR_Q_AW-1:0] slot(input logic [3:0] pri, input logic [4:0] idx);
        slot = `SCR_Q_AW'(pri) * `SCR_Q_AW'(`SCR_COLS) + `SCR_Q_AW'(idx);
    endfunction

    // lowest occupied level wins
    always_comb begin
        low_lvl = 4'd0;
        for (int i = `SCR_PRI_LEVELS - 1; i >= 0; i--) begin
            if (occupied[i]) low_lvl = 4'(i);
        end
    end

    assign ent_pri_o = lvl;

    always_ff @(posedge CLK96) begin
        if (push_i) q_ram[slot(push_pri_i, cnt[push_pri_i])] <= entry_i;
        if (st == Q_READ) ent_o <= q_ram[slot(lvl, rd_idx)];
    end

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            st          <= Q_IDLE;
            occupied    <= '0;
            lvl         <= 4'd0;
            rd_idx      <= 5'd0;
            ent_valid_o <= 1'b0;
            line_done_o <= 1'b0;
            for (int i = 0; i < `SCR_PRI_LEVELS; i++) cnt[i] <= 5'd0;
        end else begin
            ent_valid_o <= 1'b0;
            line_done_o <= 1'b0;
            if (push_i) begin
                cnt[push_pri_i]      <= cnt[push_pri_i] + 5'd1;
                occupied[push_pri_i] <= 1'b1;
            end
            case (st)
                Q_IDLE: if (scan_done_i) begin
                    if (occupied == '0) line_done_o <= 1'b1;  // empty line
                    else st <= Q_PICK;
                end
                Q_PICK: begin
                    if (occupied == '0) begin
                        line_done_o <= 1'b1;
                        for (int i = 0; i < `SCR_PRI_LEVELS; i++) cnt[i] <= 5'd0;
                        st <= Q_IDLE;
                    end else begin
                        lvl               <= low_lvl;
                        rd_idx            <= 5'd0;
                        occupied[low_lvl] <= 1'b0;
                        st                <= Q_READ;
                    end
                end
                Q_READ: begin
                    ent_valid_o <= 1'b1;   // ent_o lands with it
                    st          <= Q_WAIT;
                end
                Q_WAIT: if (tile_done_i) begin
                    if (rd_idx + 5'd1 == cnt[lvl]) begin
                        st <= Q_PICK;      // level empty
                    end else begin
                        rd_idx <= rd_idx + 5'd1;
                        st     <= Q_READ;
                    end
                end
                default: st <= Q_IDLE;
            endcase
        end
    end

endmodule

//--- scroll_layer/tile_render.sv
`timescale 1ns/1ps
`include "scroll_cfg.svh"

module tile_render
    import scroll_pkg::*;
(
    input  logic                   CLK96,
    input  logic                   RESET96,
    input  logic                   ent_valid_i,
    input  tile_entry_t            ent_i,
    input  logic [3:0]             ent_pri_i,
    input  logic [8:0]             vrender_i,
    input  logic signed [12:0]     scroll_y_i,
    input  logic                   gfx_ok_i,
    input  logic [31:0]            gfx_data_i,
    output logic                   gfx_cs_o,
    output logic [14:0]            gfx_tile_o,
    output logic [15:0]            gfx_offs_o,
    output logic [3:0]             gfx_bank_o,
    output logic                   buf_we_o,
    output logic [`SCR_BUF_AW-1:0] buf_addr_o,
    output pix_word_t              buf_data_o,
    output logic                   tile_done_o
);

    typedef enum logic [1:0] {R_IDLE, R_REQ, R_PIX} r_st_t;

    r_st_t              st;
    logic               half;      // left or right 8 pixels
    logic [2:0]         pix_idx;
    gfx_slice_u         slice;
    logic signed [15:0] xpos_q;
    logic [6:0]         pal_q;
    logic [3:0]         pri_q;

    // only the row inside the tile matters for the offset
    wire [3:0] line_lo = vrender_i[3:0] + scroll_y_i[3:0];

    function automatic logic [15:0] slice_offs(input logic h);
        slice_offs = {9'd0, line_lo[3], h, line_lo[2:0], 2'b00};
    endfunction

    wire [3:0]         pix_code = slice.pix[pix_idx];
    wire signed [15:0] pix_pos  = xpos_q + $signed({12'd0, half, pix_idx});
    wire               on_line  = (pix_pos >= 16'sd0) && (pix_pos < 16'(`SCR_VISIBLE_W));
    wire               pix_wr   = (pix_code != 4'd0) && on_line;

    always_ff @(posedge CLK96 or posedge RESET96) begin
        if (RESET96) begin
            st          <= R_IDLE;
            half        <= 1'b0;
            pix_idx     <= 3'd0;
            gfx_cs_o    <= 1'b0;
            buf_we_o    <= 1'b0;
            tile_done_o <= 1'b0;
        end else begin
            buf_we_o    <= 1'b0;
            tile_done_o <= 1'b0;
            case (st)
                R_IDLE: if (ent_valid_i) begin
                    gfx_cs_o <= 1'b1;
                    half     <= 1'b0;
                    st       <= R_REQ;
                end
                R_REQ: if (gfx_ok_i) begin   // cs holds until ok
                    gfx_cs_o <= 1'b0;
                    pix_idx  <= 3'd0;
                    st       <= R_PIX;
                end
                R_PIX: begin
                    buf_we_o <= pix_wr;
                    pix_idx  <= pix_idx + 3'd1;
                    if (pix_idx == 3'd7) begin
                        if (!half) begin
                            half     <= 1'b1;
                            gfx_cs_o <= 1'b1;  // right half request
                            st       <= R_REQ;
                        end else begin
                            tile_done_o <= 1'b1;
                            st          <= R_IDLE;
                        end
                    end
                end
                default: st <= R_IDLE;
            endcase
        end
    end

    always_ff @(posedge CLK96) begin
        case (st)
            R_IDLE: if (ent_valid_i) begin
                xpos_q     <= ent_i.xpos;
                pal_q      <= ent_i.attr[6:0];
                pri_q      <= ent_pri_i;
                gfx_tile_o <= {ent_i.tile[12:0], 2'b00};
                gfx_bank_o <= {1'b0, ent_i.tile[15:13]};
                gfx_offs_o <= slice_offs(1'b0);
            end
            R_REQ: if (gfx_ok_i) slice.raw <= gfx_data_i;
            R_PIX: begin
                buf_addr_o      <= pix_pos[`SCR_BUF_AW-1:0];
                buf_data_o.pri  <= pri_q;
                buf_data_o.pal  <= pal_q;
                buf_data_o.code <= pix_code;
                if (pix_idx == 3'd7 && !half) gfx_offs_o <= slice_offs(1'b1);
            end
            default: ;
        endcase
    end

endmodule

//--- scroll_layer/scroll_layer.sv
`timescale 1ns/1ps
`include "scroll_cfg.svh"

module scroll_layer
    import scroll_pkg::*;
(
    input  logic                   CLK96,
    input  logic                   RESET96,
    input  logic                   hb_i,
    input  logic                   vb_i,
    input  logic [8:0]             vrender_i,
    input  logic signed [12:0]     scroll_x_i,
    input  logic signed [12:0]     scroll_y_i,
    output logic [`SCR_MAP_AW-1:0] map_addr_o,
    input  logic [15:0]            map_dout_i,
    output logic                   gfx_cs_o,
    output logic [14:0]            gfx_tile_o,
    output logic [15:0]            gfx_offs_o,
    output logic [3:0]             gfx_bank_o,
    input  logic                   gfx_ok_i,
    input  logic [31:0]            gfx_data_i,
    output logic                   buf_we_o,
    output logic [`SCR_BUF_AW-1:0] buf_addr_o,
    output pix_word_t              buf_data_o,
    output logic                   busy_o,
    output logic                   done_o
);

    logic        push;
    tile_entry_t push_entry;
    logic [3:0]  push_pri;
    logic        scan_done;
    logic        line_done;
    logic        ent_valid;
    tile_entry_t ent;
    logic [3:0]  ent_pri;
    logic        tile_done;

    // decode: tilemap columns into queue entries
    tilemap_scan u_scan (
        .CLK96       (CLK96),
        .RESET96     (RESET96),
        .hb_i        (hb_i),
        .vb_i        (vb_i),
        .vrender_i   (vrender_i),
        .scroll_x_i  (scroll_x_i),
        .scroll_y_i  (scroll_y_i),
        .map_dout_i  (map_dout_i),
        .line_done_i (line_done),
        .map_addr_o  (map_addr_o),
        .push_o      (push),
        .entry_o     (push_entry),
        .push_pri_o  (push_pri),
        .scan_done_o (scan_done),
        .busy_o      (busy_o),
        .done_o      (done_o)
    );

    pri_queue u_queue (
        .CLK96       (CLK96),
        .RESET96     (RESET96),
        .push_i      (push),
        .entry_i     (push_entry),
        .push_pri_i  (push_pri),
        .scan_done_i (scan_done),
        .tile_done_i (tile_done),
        .ent_valid_o (ent_valid),
        .ent_o       (ent),
        .ent_pri_o   (ent_pri),
        .line_done_o (line_done)
    );

    tile_render u_render (
        .CLK96       (CLK96),
        .RESET96     (RESET96),
        .ent_valid_i (ent_valid),
        .ent_i       (ent),
        .ent_pri_i   (ent_pri),
        .vrender_i   (vrender_i),
        .scroll_y_i  (scroll_y_i),
        .gfx_ok_i    (gfx_ok_i),
        .gfx_data_i  (gfx_data_i),
        .gfx_cs_o    (gfx_cs_o),
        .gfx_tile_o  (gfx_tile_o),
        .gfx_offs_o  (gfx_offs_o),
        .gfx_bank_o  (gfx_bank_o),
        .buf_we_o    (buf_we_o),
        .buf_addr_o  (buf_addr_o),
        .buf_data_o  (buf_data_o),
        .tile_done_o (tile_done)
    );

endmodule

//--- testbench/scroll_layer_assertions.sv
`timescale 1ns/1ps
`include "scroll_cfg.svh"

module scroll_layer_assertions (
    input logic                   CLK96,
    input logic                   RESET96,
    input logic                   cs_i,     // graphics request
    input logic                   ok_i,
    input logic                   done_i,
    input logic                   busy_i,
    input logic                   we_i,     // line buffer write strobe
    input logic [`SCR_BUF_AW-1:0] addr_i
);

    // request must stay up until the graphics port answers
    a_cs_hold: assert property (@(posedge CLK96) disable iff (RESET96)
        cs_i && !ok_i |=> cs_i)
        else $error("graphics request dropped before ok");

    a_done_pulse: assert property (@(posedge CLK96) disable iff (RESET96)
        done_i |=> !done_i)
        else $error("done lasted more than one cycle");

    // writes only happen inside a line
    a_we_busy: assert property (@(posedge CLK96) disable iff (RESET96)
        we_i |-> busy_i)
        else $error("line buffer write while the layer is idle");

    a_we_visible: assert property (@(posedge CLK96) disable iff (RESET96)
        we_i |-> addr_i < 9'(`SCR_VISIBLE_W))
        else $error("line buffer write outside the visible width");

endmodule

//--- testbench/tb_scroll_layer.sv
`timescale 1ns/1ps
`include "scroll_cfg.svh"

module tb_scroll_layer
    import scroll_pkg::*;
();

    localparam int NUM_LINES   = 20;
    localparam int LINE_CYCLES = 3000;     // per line budget
    localparam int WATCHDOG    = (NUM_LINES + 3) * LINE_CYCLES + 200;

    logic                   CLK96    = 1'b0;
    logic                   RESET96  = 1'b1;
    logic                   hb       = 1'b1;
    logic                   vb       = 1'b0;
    logic [8:0]             vrender  = 9'd0;
    logic signed [12:0]     scroll_x = 13'sd0;
    logic signed [12:0]     scroll_y = 13'sd0;
    logic [`SCR_MAP_AW-1:0] map_addr;
    logic [15:0]            map_dout = 16'd0;
    logic                   gfx_cs_o;
    logic [14:0]            gfx_tile_o;
    logic [15:0]            gfx_offs_o;
    logic [3:0]             gfx_bank_o;
    logic                   gfx_ok   = 1'b0;
    logic [31:0]            gfx_data = 32'd0;
    logic                   buf_we_o;
    logic [`SCR_BUF_AW-1:0] buf_addr_o;
    pix_word_t              buf_data_o;
    logic                   busy_o;
    logic                   done_o;

    logic [15:0] map_mem [2**`SCR_MAP_AW];
    logic [23:0] exp_wr [$];               // {addr, pri, pal, code}
    logic [34:0] exp_req [$];              // {bank, tile, offs}
    logic [31:0] rng_stim  = 32'd30;
    logic [31:0] rng_gfx   = 32'd30;
    logic        gfx_armed = 1'b0;
    int          gfx_wait  = 0;
    int          done_count    = 0;
    int          lines_started = 0;

    scroll_layer u_scroll_layer (
        .CLK96      (CLK96),
        .RESET96    (RESET96),
        .hb_i       (hb),
        .vb_i       (vb),
        .vrender_i  (vrender),
        .scroll_x_i (scroll_x),
        .scroll_y_i (scroll_y),
        .map_addr_o (map_addr),
        .map_dout_i (map_dout),
        .gfx_cs_o   (gfx_cs_o),
        .gfx_tile_o (gfx_tile_o),
        .gfx_offs_o (gfx_offs_o),
        .gfx_bank_o (gfx_bank_o),
        .gfx_ok_i   (gfx_ok),
        .gfx_data_i (gfx_data),
        .buf_we_o   (buf_we_o),
        .buf_addr_o (buf_addr_o),
        .buf_data_o (buf_data_o),
        .busy_o     (busy_o),
        .done_o     (done_o)
    );

    bind scroll_layer scroll_layer_assertions u_assertions (
        .CLK96   (CLK96),
        .RESET96 (RESET96),
        .cs_i    (gfx_cs_o),
        .ok_i    (gfx_ok_i),
        .done_i  (done_o),
        .busy_i  (busy_o),
        .we_i    (buf_we_o),
        .addr_i  (buf_addr_o)
    );

    initial begin
        forever #20 CLK96 = ~CLK96;
    end

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_stim();
        rng_stim = xorshift32(rng_stim);
        return rng_stim;
    endfunction

    // graphics ROM contents, a hash of the request fields
    function automatic logic [31:0] gfx_hash(input logic [14:0] tile, input logic [3:0] bank,
                                             input logic [15:0] offs);
        logic [31:0] h;
        h = {offs, tile, 1'b1} ^ {bank, 28'h3C6EF36};
        h = xorshift32(xorshift32(h));
        if (h[31]) h = h & 32'hF0F0_0FF0;   // some transparent pixels
        return h;
    endfunction

    // tilemap RAM, one cycle read latency
    always @(posedge CLK96) map_dout <= map_mem[map_addr];

    always @(posedge CLK96) begin : gfx_responder
        logic [34:0] got;
        logic [34:0] want;
        int          delay;
        if (gfx_ok) begin
            gfx_ok    <= 1'b0;
            gfx_armed <= 1'b0;
        end else if (!RESET96 && gfx_cs_o && !gfx_armed) begin
            got = {gfx_bank_o, gfx_tile_o, gfx_offs_o};
            assert (exp_req.size() > 0)
                else report_error("graphics request while the model expects none");
            want = exp_req.pop_front();
            assert (got == want)
                else report_error($sformatf("MISMATCH at %0t: request %h, expected %h",
                                            $time, got, want));
            rng_gfx = xorshift32(rng_gfx);
            delay = int'(rng_gfx % 32'd6);
            gfx_armed <= 1'b1;
            gfx_wait  <= delay;
            if (delay == 0) begin
                gfx_ok   <= 1'b1;
                gfx_data <= gfx_hash(gfx_tile_o, gfx_bank_o, gfx_offs_o);
            end
        end else if (gfx_armed && gfx_wait > 0) begin
            if (gfx_wait == 1) begin
                gfx_ok   <= 1'b1;
                gfx_data <= gfx_hash(gfx_tile_o, gfx_bank_o, gfx_offs_o);
            end
            gfx_wait <= gfx_wait - 1;
        end
    end

    always @(posedge CLK96) begin : write_monitor
        logic [23:0] want;
        if (!RESET96 && done_o) done_count <= done_count + 1;
        if (!RESET96 && buf_we_o) begin
            assert (exp_wr.size() > 0)
                else report_error("line buffer write beyond the expected list");
            want = exp_wr.pop_front();
            assert ({buf_addr_o, buf_data_o} == want)
                else report_error($sformatf(
                    "MISMATCH at %0t: write addr %0d data %h, expected addr %0d data %h",
                    $time, buf_addr_o, buf_data_o, want[23:15], want[14:0]));
        end
    end

    task automatic fill_tilemap(input logic blank);
        logic [31:0] r;
        for (int a = 0; a < 2**`SCR_MAP_AW; a++) begin
            r = next_stim();
            if (blank) map_mem[a] = 16'd0;
            else if (a % 2 == 1) map_mem[a] = (r[1:0] == 2'd0) ? 16'd0 : r[15:0];
            else map_mem[a] = r[31:16];     // attribute word
        end
    endtask

    // expected requests and writes for the line, in drain order
    task automatic build_line_model();
        logic [9:0]  line_fine;
        logic [5:0]  tile_row;
        logic [4:0]  map_row;
        logic [4:0]  map_col;
        logic [12:0] base;
        logic [15:0] tile [`SCR_COLS];
        logic [15:0] attr [`SCR_COLS];
        logic        kept [`SCR_COLS];
        logic [14:0] tile_f;
        logic [3:0]  bank;
        logic [15:0] offs;
        gfx_slice_u  slice;
        int          pos;
        line_fine = 10'(vrender) + 10'(scroll_y[3:0]);
        tile_row  = line_fine[9:4];
        map_row   = scroll_y[8:4] + tile_row[4:0];
        for (int c = 0; c < `SCR_COLS; c++) begin
            map_col = scroll_x[8:4] + 5'(c);
            base    = 13'(map_row) * 13'd64 + 13'(map_col) * 13'd2;
            tile[c] = map_mem[base + 13'd1];
            attr[c] = map_mem[base];
            kept[c] = (tile[c] != 16'd0) && (17'(tile[c]) <= `SCR_MAX_TILE);
        end
        for (int p = 0; p < `SCR_PRI_LEVELS; p++) begin
            for (int c = 0; c < `SCR_COLS; c++) begin
                if (kept[c] && int'(attr[c][11:8]) == p) begin
                    for (int h = 0; h < 2; h++) begin
                        tile_f = 15'(tile[c][12:0]) * 15'd4;
                        bank   = 4'(tile[c][15:13]);
                        offs   = 16'(line_fine[3]) * 16'd64 + 16'(h) * 16'd32
                               + 16'(line_fine[2:0]) * 16'd4;
                        exp_req.push_back({bank, tile_f, offs});
                        slice.raw = gfx_hash(tile_f, bank, offs);
                        for (int i = 0; i < 8; i++) begin
                            pos = c * 16 - int'(scroll_x[3:0]) + 8 * h + i;
                            if (slice.pix[i] != 4'd0 && pos >= 0 && pos < `SCR_VISIBLE_W)
                                exp_wr.push_back({9'(pos), 4'(p), attr[c][6:0], slice.pix[i]});
                        end
                    end
                end
            end
        end
    endtask

    task automatic wait_line_done();
        int cycles;
        cycles = 0;
        do begin
            @(posedge CLK96);
            cycles++;
        end while (!done_o && cycles < LINE_CYCLES);
        assert (done_o) else report_error("line did not finish within the cycle limit");
    endtask

    task automatic run_line(input logic [8:0] vr, input logic signed [12:0] sx,
                            input logic signed [12:0] sy, input logic vb_lvl,
                            input logic blank, input logic restart);
        fill_tilemap(blank);
        @(posedge CLK96);
        vrender  <= vr;
        scroll_x <= sx;
        scroll_y <= sy;
        vb       <= vb_lvl;
        hb       <= 1'b1;
        @(posedge CLK96);
        build_line_model();
        hb <= 1'b0;                  // falling hblank starts the line
        lines_started++;
        if (restart) begin
            repeat (10) @(posedge CLK96);
            hb <= 1'b1;
            @(posedge CLK96);
            hb <= 1'b0;              // second start while busy
        end
        wait_line_done();
        repeat (4) @(posedge CLK96);
        assert (exp_wr.size() == 0) else report_error("line ended with writes still missing");
        assert (exp_req.size() == 0) else report_error("line ended with requests still missing");
        assert (done_count == lines_started) else report_error("done count differs from lines");
        assert (!busy_o) else report_error("busy still high after done");
    endtask

    task automatic check_vblank_hold(input logic [8:0] vr);
        @(posedge CLK96);
        vrender <= vr;
        vb      <= 1'b1;
        hb      <= 1'b1;
        @(posedge CLK96);
        hb <= 1'b0;
        repeat (100) begin
            @(posedge CLK96);
            assert (!busy_o && !gfx_cs_o && !buf_we_o)
                else report_error("line started during vblank on a nonzero line");
        end
        assert (done_count == lines_started) else report_error("done pulsed without a line");
    endtask

    initial begin : watchdog
        repeat (WATCHDOG) @(posedge CLK96);
        report_error("timeout, the run did not finish in time");
    end

    initial begin : stimulus
        logic [8:0]         vr;
        logic signed [12:0] sx;
        logic signed [12:0] sy;
        fill_tilemap(1'b1);
        repeat (8) @(posedge CLK96);
        RESET96 <= 1'b0;
        repeat (16) begin            // hblank held high, nothing may start
            @(posedge CLK96);
            assert (!busy_o && !done_o && !gfx_cs_o && !buf_we_o)
                else report_error("outputs active after reset without a line start");
        end
        for (int i = 0; i < NUM_LINES; i++) begin
            vr = 9'(next_stim());
            sx = 13'(next_stim());
            sy = 13'(next_stim());
            case (i)
                1: begin
                    sx = -13'sd1;    // coarse 31, fine 15
                    sy = 13'sh1FF;
                end
                2: begin
                    sx = 13'sh010;
                    sy = 13'sh00F;
                    vr = 9'd511;
                end
                3: begin
                    sx = 13'sh1F0;
                    sy = -13'sd16;
                    vr = 9'd0;
                end
                default: ;
            endcase
            run_line(vr, sx, sy, 1'b0, i == 0, i % 4 == 2);
        end
        check_vblank_hold(9'd100);
        run_line(9'd0, 13'sh123, 13'sh045, 1'b1, 1'b0, 1'b0);   // line 0 in vblank
        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+common
common/scroll_pkg.sv
scroll_layer/tilemap_scan.sv
scroll_layer/pri_queue.sv
scroll_layer/tile_render.sv
scroll_layer/scroll_layer.sv
testbench/scroll_layer_assertions.sv
testbench/tb_scroll_layer.sv

//--- Makefile
TOP := tb_scroll_layer

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f verilog.f --top-module $(TOP)

# a $fatal or a failed assertion ends the binary with a nonzero status
sim:
	verilator --binary --timing --assert -f verilog.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir
